/* scan_config.svh */
/*
 * Octet scanner configuration
 * Line framing constants, frame limits, header field offsets,
 * configuration memory map and the CRC32 residue
 */
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// GMII framing octets
`define SCAN_PREAMBLE 8'h55
`define SCAN_SFD 8'hd5

// Non-data cycles required between frames, preamble included
`define SCAN_IFG_MIN 10
// Octet count at which a frame is abandoned
`define SCAN_MAX_LEN 1536
`define SCAN_CNT_W 11

// Configuration memory map, our MAC then our IP
`define SCAN_MAC_BASE 4'd0
`define SCAN_IP_BASE 4'd6
`define SCAN_MAC_LEN 6
`define SCAN_IP_LEN 4

// Field offsets from the first octet after the SFD
`define SCAN_SRC_MAC_OFS 6
`define SCAN_ARP_HDR_OFS 12
`define SCAN_ARP_HDR_LEN 10
`define SCAN_ARP_TIP_OFS 38

// Register value after running over data plus FCS
`define SCAN_CRC_RESIDUE 32'hdebb20e3

`endif

/* scan_pkg.sv */
/*
 * Shared scanner functions
 * CRC32 octet update in reflected form and the ARP request header template
 */
`include "scan_config.svh"

package scan_pkg;

	// Reflected IEEE 802.3 polynomial
	localparam logic [31:0] CRC32_POLY = 32'hedb88320;

	// One octet through the CRC, LSB first as it goes on the wire
	function automatic logic [31:0] crc32_octet(input logic [31:0] crc, input logic [7:0] octet);
		logic [31:0] c;
		logic fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ octet[i];
			c = c >> 1;
			if (fb)
				c = c ^ CRC32_POLY;
		end
		return c;
	endfunction

	// Expected octet of an ARP request, offsets 12 to 21
	function automatic logic [7:0] arp_template(input logic [`SCAN_CNT_W-1:0] ofs);
		case (ofs)
			12: return 8'h08;  // Ethertype ARP
			13: return 8'h06;
			14: return 8'h00;  // Hardware type Ethernet
			15: return 8'h01;
			16: return 8'h08;  // Protocol type IPv4
			17: return 8'h00;
			18: return 8'h06;  // Hardware address length
			19: return 8'h04;  // Protocol address length
			20: return 8'h00;  // Operation, request
			21: return 8'h01;
			default: return 8'h00;
		endcase
	endfunction

endpackage

/* scan_if.sv */
/*
 * Framer to checker link
 * Counted octet stream, one cycle behind the line input
 */
`timescale 1ns/1ps
`include "scan_config.svh"

interface scan_if;
	// Index of the octet on data, valid while gate is high
	logic [`SCAN_CNT_W-1:0] cnt;
	logic [7:0] data;
	// High for every frame octet, FCS included
	logic gate;
	// Marks octet 0
	logic first;
	// Cycle after the final octet, not raised for abandoned frames
	logic last;

	modport framer (output cnt, data, gate, first, last);
	// Consumer side
	modport check (input cnt, data, gate, first, last);
endinterface

/* rx_framer.sv */
/*
 * GMII receive framer
 * Preamble and SFD check, inter-frame gap and length limits,
 * octet counting and the two-stage delay to the output stream
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module rx_framer (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] eth_in,
	input  logic eth_in_s,
	scan_if.framer link,
	output logic [7:0] odata,
	output logic odata_s,
	output logic odata_f,
	output logic [`SCAN_CNT_W-1:0] pack_len
);

	localparam int IFG_W = $clog2(`SCAN_IFG_MIN + 1);
	localparam logic [IFG_W-1:0] IFG_MIN = `SCAN_IFG_MIN;
	localparam logic [`SCAN_CNT_W-1:0] MAX_LEN = `SCAN_MAX_LEN;

	// One-hot line state
	logic st_idle, st_pre, st_data, st_drop;
	logic [IFG_W-1:0] ifg_cnt;
	logic [`SCAN_CNT_W-1:0] pack_cnt;
	logic too_long, capture;
	// Delay line
	logic v1, v2, ab1, first_r, f_r;
	logic [7:0] data_d1, data_d2;
	logic [`SCAN_CNT_W-1:0] cnt_d1;
	logic last;

	assign too_long = pack_cnt >= MAX_LEN;
	// Octet accepted into the frame this cycle
	assign capture = st_data & eth_in_s & ~too_long;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			st_idle <= 1'b1;
			st_pre <= 1'b0;
			st_data <= 1'b0;
			st_drop <= 1'b0;
			// Line counts as quiet through reset
			ifg_cnt <= IFG_MIN;
			pack_cnt <= '0;
		end else begin
			// Gap counter saturates, cleared by any data or dropped octet
			if (st_idle | st_pre) begin
				if (ifg_cnt != IFG_MIN)
					ifg_cnt <= ifg_cnt + 1'b1;
			end else begin
				ifg_cnt <= '0;
			end
			pack_cnt <= (st_data & eth_in_s) ? pack_cnt + 1'b1 : '0;
			if (st_idle & eth_in_s) begin
				st_idle <= 1'b0;
				if (eth_in == `SCAN_PREAMBLE)
					st_pre <= 1'b1;
				else
					st_drop <= 1'b1;
			end
			if (st_pre) begin
				if (!eth_in_s) begin
					st_pre <= 1'b0;
					st_idle <= 1'b1;
				end else if (eth_in == `SCAN_SFD) begin
					st_pre <= 1'b0;
					// Too little gap since the last frame
					if (ifg_cnt == IFG_MIN)
						st_data <= 1'b1;
					else
						st_drop <= 1'b1;
				end else if (eth_in != `SCAN_PREAMBLE) begin
					st_pre <= 1'b0;
					st_drop <= 1'b1;
				end
			end
			if (st_data) begin
				if (!eth_in_s) begin
					st_data <= 1'b0;
					st_idle <= 1'b1;
				end else if (too_long) begin
					st_data <= 1'b0;
					st_drop <= 1'b1;
				end
			end
			// Discard the tail until the strobe falls
			if (st_drop & ~eth_in_s) begin
				st_drop <= 1'b0;
				st_idle <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			ab1 <= 1'b0;
			first_r <= 1'b0;
			f_r <= 1'b0;
			cnt_d1 <= '0;
			pack_len <= '0;
		end else begin
			v1 <= capture;
			v2 <= v1;
			// Length abort, suppresses the end mark
			ab1 <= st_data & eth_in_s & too_long;
			first_r <= capture & (pack_cnt == '0);
			f_r <= last;
			if (capture)
				cnt_d1 <= pack_cnt;
			// Index of the last octet plus one
			if (last)
				pack_len <= cnt_d1 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			data_d1 <= eth_in;
		data_d2 <= data_d1;
	end

	assign last = v2 & ~v1 & ~ab1;

	assign link.cnt = cnt_d1;
	assign link.data = data_d1;
	assign link.gate = v1;
	assign link.first = first_r;
	assign link.last = last;

	// Second stage feeds the output
	assign odata = data_d2;
	assign odata_s = v2;
	assign odata_f = f_r;

endmodule

/* addr_match.sv */
/*
 * Address checker
 * Walks the configuration memory in step with the stream and compares
 * destination MAC, ARP target IP and the source MAC group bit
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module addr_match (
	input  logic clk,
	input  logic rst_n,
	scan_if.check link,
	output logic [3:0] ip_a,
	input  logic [7:0] ip_d,
	output logic mac_ok,
	output logic tip_ok,
	output logic src_unicast
);

	localparam logic [`SCAN_CNT_W-1:0] TIP_OFS = `SCAN_ARP_TIP_OFS;

	logic [`SCAN_CNT_W-1:0] nxt, tip_idx;
	logic hit, in_mac, in_tip;

	// Index of the octet due on link next cycle, octet 0 when idle
	assign nxt = link.gate ? link.cnt + 1'b1 : '0;
	assign tip_idx = nxt - TIP_OFS;

	// Memory answers one cycle after the address
	always_comb begin
		if (nxt < `SCAN_MAC_LEN)
			ip_a = `SCAN_MAC_BASE + nxt[3:0];
		else if (nxt >= TIP_OFS && nxt < TIP_OFS + `SCAN_IP_LEN)
			ip_a = `SCAN_IP_BASE + tip_idx[3:0];
		else
			ip_a = `SCAN_MAC_BASE;
	end

	assign hit = link.data == ip_d;
	// Comparison windows
	assign in_mac = link.gate && link.cnt < `SCAN_MAC_LEN;
	assign in_tip = link.gate && link.cnt >= TIP_OFS && link.cnt < TIP_OFS + `SCAN_IP_LEN;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mac_ok <= 1'b0;
			tip_ok <= 1'b0;
			src_unicast <= 1'b0;
		end else begin
			// Optimistic at frame start
			if (link.first) begin
				mac_ok <= 1'b1;
				tip_ok <= 1'b1;
				src_unicast <= 1'b0;
			end
			if (in_mac & ~hit)
				mac_ok <= 1'b0;
			if (in_tip & ~hit)
				tip_ok <= 1'b0;
			// Group bit is the first bit on the wire
			if (link.gate && link.cnt == `SCAN_SRC_MAC_OFS)
				src_unicast <= ~link.data[0];
		end
	end

endmodule

/* arp_match.sv */
/*
 * ARP request checker
 * Compares Ethernet header octets 12 to 21 with the request template
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module arp_match import scan_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	scan_if.check link,
	output logic arp_ok
);

	logic [`SCAN_CNT_W-1:0] nxt;
	logic [7:0] tmpl;
	logic want;

	// Template is fetched one octet ahead
	assign nxt = link.gate ? link.cnt + 1'b1 : '0;

	always_ff @(posedge clk) begin
		tmpl <= arp_template(nxt);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want <= 1'b0;
			arp_ok <= 1'b0;
		end else begin
			want <= nxt >= `SCAN_ARP_HDR_OFS && nxt < `SCAN_ARP_HDR_OFS + `SCAN_ARP_HDR_LEN;
			if (link.first)
				arp_ok <= 1'b1;
			// Any header difference kills it
			if (want && link.gate && link.data != tmpl)
				arp_ok <= 1'b0;
		end
	end

endmodule

/* crc32_check.sv */
/*
 * CRC32 checker
 * Runs the FCS polynomial over the whole frame and flags the good residue
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module crc32_check import scan_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	scan_if.check link,
	output logic crc_ok
);

	localparam logic [31:0] CRC_SEED = 32'hffffffff;

	logic [31:0] crc, crc_nxt;

	// Octet 0 starts from the seed, not the previous frame
	assign crc_nxt = crc32_octet(link.first ? CRC_SEED : crc, link.data);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc <= CRC_SEED;
			crc_ok <= 1'b0;
		end else if (link.gate) begin
			crc <= crc_nxt;
			// Final octet leaves the verdict ready for last
			crc_ok <= crc_nxt == `SCAN_CRC_RESIDUE;
		end
	end

endmodule

/* scanner.sv */
/*
 * Receive packet scanner
 * Frames the GMII stream, forwards it two cycles late and reports
 * CRC, address and ARP request status at each frame end
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module scanner (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] eth_in,
	input  logic eth_in_s,
	// Configuration memory, one cycle latency
	output logic [3:0] ip_a,
	input  logic [7:0] ip_d,
	// Stream to the next stage
	output logic [7:0] odata,
	output logic odata_s,
	output logic odata_f,
	output logic status_valid,
	output logic [3:0] status_vec,
	output logic [`SCAN_CNT_W-1:0] pack_len
);

	logic mac_ok, tip_ok, src_unicast, arp_ok, crc_ok;
	logic arp_req;

	scan_if link ();

	rx_framer i_framer (
		.clk(clk),
		.rst_n(rst_n),
		.eth_in(eth_in),
		.eth_in_s(eth_in_s),
		.link(link.framer),
		.odata(odata),
		.odata_s(odata_s),
		.odata_f(odata_f),
		.pack_len(pack_len)
	);

	addr_match i_addr (
		.clk(clk),
		.rst_n(rst_n),
		.link(link.check),
		.ip_a(ip_a),
		.ip_d(ip_d),
		.mac_ok(mac_ok),
		.tip_ok(tip_ok),
		.src_unicast(src_unicast)
	);

	arp_match i_arp (.clk(clk), .rst_n(rst_n), .link(link.check), .arp_ok(arp_ok));

	crc32_check i_crc (.clk(clk), .rst_n(rst_n), .link(link.check), .crc_ok(crc_ok));

	// Answerable ARP request only
	assign arp_req = arp_ok & tip_ok & src_unicast & crc_ok;

	// Summary held until the next frame ends
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_vec <= '0;
			status_valid <= 1'b0;
		end else begin
			status_valid <= link.last;
			if (link.last)
				status_vec <= {src_unicast, mac_ok, crc_ok, arp_req};
		end
	end

endmodule

/* scanner_asserts.sv */
/*
 * Scanner output protocol assertions
 * Bound to the scanner top level, watches the frame end and summary strobes
 */
`timescale 1ns/1ps

module scanner_asserts (
	input logic clk,
	input logic rst_n,
	input logic odata_s,
	input logic odata_f,
	input logic status_valid
);

	// Count of failed assertions
	int fail_cnt = 0;

	// Summary is a single-cycle pulse
	status_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		status_valid |=> !status_valid)
		else begin
			$error("status_valid held high for two cycles");
			fail_cnt++;
		end

	// Frame end mark and summary come together
	end_align: assert property (@(posedge clk) disable iff (!rst_n)
		odata_f == status_valid)
		else begin
			$error("odata_f and status_valid disagree");
			fail_cnt++;
		end

	// End mark only right after the last forwarded octet
	end_after_data: assert property (@(posedge clk) disable iff (!rst_n)
		odata_f |-> $past(odata_s) && !odata_s)
		else begin
			$error("odata_f without a preceding odata_s octet");
			fail_cnt++;
		end

endmodule

/* tb_scanner.sv */
/*
 * Scanner testbench
 * Builds Ethernet frames from a stimulus table, drives them on the GMII
 * input and checks the forwarded octets, frame length and status summary
 */
`timescale 1ns/1ps
`include "scan_config.svh"

module tb_scanner import scan_pkg::*; ();

	// Frame kinds
	localparam int K_ARP = 0;
	localparam int K_IP = 1;
	localparam int K_ARP_OTHER = 2;
	localparam int K_ARP_MCAST = 3;
	// Corruptions
	localparam int C_NONE = 0;
	localparam int C_PAYLOAD = 1;
	localparam int C_PREAMBLE = 2;
	// Good frame sent just before, so gap counts from a real frame
	localparam int C_LEAD = 3;

	localparam int N_ROWS = 8;
	localparam int FRAME_LEN = 60;
	localparam int STATUS_TIMEOUT = 200;
	localparam int DROP_WAIT = 40;

	localparam logic [47:0] OUR_MAC = 48'h021a2b3c4d5e;
	localparam logic [31:0] OUR_IP = 32'hc0a8010a;
	localparam logic [31:0] OTHER_IP = 32'hc0a80163;

	typedef struct {
		string name;
		int kind;
		int corrupt;
		int gap;
		logic [3:0] expv;
		bit silent;
	} row_t;

	logic clk, rst_n, eth_in_s;
	logic [7:0] eth_in, ip_d, odata;
	logic [3:0] ip_a, status_vec;
	logic odata_s, odata_f, status_valid;
	logic [`SCAN_CNT_W-1:0] pack_len;

	logic [7:0] cfg_mem [16];
	logic [7:0] frm [$];
	logic [7:0] got [$];
	int sv_cnt;
	logic [3:0] got_vec;
	logic [`SCAN_CNT_W-1:0] got_len;
	int seed;
	row_t tbl [N_ROWS];

	scanner i_scanner (
		.clk(clk),
		.rst_n(rst_n),
		.eth_in(eth_in),
		.eth_in_s(eth_in_s),
		.ip_a(ip_a),
		.ip_d(ip_d),
		.odata(odata),
		.odata_s(odata_s),
		.odata_f(odata_f),
		.status_valid(status_valid),
		.status_vec(status_vec),
		.pack_len(pack_len)
	);

	bind scanner scanner_asserts i_asserts (.clk(clk), .rst_n(rst_n), .odata_s(odata_s),
		.odata_f(odata_f), .status_valid(status_valid));

	always #50 clk = ~clk;

	// Configuration memory, one cycle read latency
	always @(posedge clk)
		ip_d <= cfg_mem[ip_a];

	// Output monitor, samples away from the active edge
	always @(negedge clk) begin
		if (odata_s)
			got.push_back(odata);
		if (status_valid) begin
			sv_cnt++;
			got_vec = status_vec;
			got_len = pack_len;
		end
	end

	task automatic fail_out(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Bound protocol checker
	always @(negedge clk) begin
		if (i_scanner.i_asserts.fail_cnt != 0)
			fail_out($sformatf("Output protocol assertion failed, %0d failures",
				i_scanner.i_asserts.fail_cnt));
	end

	task automatic check_val(input string name, input string what,
		input logic [31:0] expv, input logic [31:0] act);
		assert (expv === act)
			else fail_out($sformatf("** Error: %s %s expected %0h actual %0h",
				name, what, expv, act));
	endtask

	task automatic drive_octet(input logic [7:0] b);
		@(posedge clk);
		eth_in <= b;
		eth_in_s <= 1'b1;
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			eth_in <= 8'h00;
			eth_in_s <= 1'b0;
		end
	endtask

	// Field goes on the wire most significant octet first
	task automatic put_field(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			frm.push_back(v[8*i +: 8]);
	endtask

	task automatic build_frame(input int kind);
		logic [31:0] crc;
		int r;
		frm.delete();
		put_field((kind == K_IP) ? OUR_MAC : 48'hffffffffffff, 6);
		// Group bit set only for the multicast source case
		put_field((kind == K_ARP_MCAST) ? 48'h0300a1b2c3d4 : 48'h0200a1b2c3d4, 6);
		if (kind == K_IP)
			put_field(48'h0800, 2);
		else
			for (int i = 12; i < 22; i++)
				frm.push_back(arp_template(i));
		while (frm.size() < FRAME_LEN) begin
			if (kind != K_IP && frm.size() == `SCAN_ARP_TIP_OFS) begin
				put_field((kind == K_ARP_OTHER) ? OTHER_IP : OUR_IP, 4);
			end else begin
				r = $random(seed);
				frm.push_back(r[7:0]);
			end
		end
		// FCS is the inverted CRC, low octet first
		crc = 32'hffffffff;
		foreach (frm[i])
			crc = crc32_octet(crc, frm[i]);
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			frm.push_back(crc[8*i +: 8]);
	endtask

	task automatic send_frame(input bit bad_pre);
		for (int i = 0; i < 7; i++)
			drive_octet((bad_pre && i == 3) ? 8'h5a : `SCAN_PREAMBLE);
		drive_octet(`SCAN_SFD);
		foreach (frm[i])
			drive_octet(frm[i]);
	endtask

	initial begin
		int t;
		int lead_len;
		clk = 1'b0;
		rst_n = 1'b0;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		ip_d = 8'h00;
		sv_cnt = 0;
		seed = 32'h326d;
		// Unused entries get an address-dependent fill
		for (int i = 0; i < 16; i++)
			cfg_mem[i] = 8'h90 ^ (8'(i) * 8'd37);
		for (int i = 0; i < 6; i++)
			cfg_mem[`SCAN_MAC_BASE + i] = OUR_MAC[47 - 8*i -: 8];
		for (int i = 0; i < 4; i++)
			cfg_mem[`SCAN_IP_BASE + i] = OUR_IP[31 - 8*i -: 8];

		tbl[0] = '{"arp_ours", K_ARP, C_NONE, 12, 4'b1011, 1'b0};
		tbl[1] = '{"ip_ours", K_IP, C_NONE, 12, 4'b1110, 1'b0};
		tbl[2] = '{"arp_bad_fcs", K_ARP, C_PAYLOAD, 12, 4'b1000, 1'b0};
		tbl[3] = '{"arp_other_ip", K_ARP_OTHER, C_NONE, 12, 4'b1010, 1'b0};
		tbl[4] = '{"arp_mcast_src", K_ARP_MCAST, C_NONE, 12, 4'b0010, 1'b0};
		tbl[5] = '{"bad_preamble", K_ARP, C_PREAMBLE, 12, 4'b0000, 1'b1};
		tbl[6] = '{"short_gap", K_ARP, C_LEAD, 1, 4'b0000, 1'b1};
		tbl[7] = '{"arp_after_drop", K_ARP, C_NONE, 12, 4'b1011, 1'b0};

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		foreach (tbl[n]) begin
			got.delete();
			sv_cnt = 0;
			lead_len = 0;
			if (tbl[n].corrupt == C_LEAD) begin
				build_frame(K_ARP);
				drive_idle(12);
				send_frame(1'b0);
				lead_len = frm.size();
			end
			build_frame(tbl[n].kind);
			// Flip a bit in the ARP sender IP after the FCS is fixed
			if (tbl[n].corrupt == C_PAYLOAD)
				frm[30] = frm[30] ^ 8'h01;
			drive_idle(tbl[n].gap);
			send_frame(tbl[n].corrupt == C_PREAMBLE);
			drive_idle(1);
			if (tbl[n].silent) begin
				// Only the lead frame, if any, may come out
				for (t = 0; t < DROP_WAIT; t++)
					@(posedge clk);
				check_val(tbl[n].name, "reports", (lead_len != 0) ? 1 : 0, sv_cnt);
				check_val(tbl[n].name, "octets", lead_len, got.size());
			end else begin
				for (t = 0; t < STATUS_TIMEOUT && sv_cnt == 0; t++)
					@(posedge clk);
				if (sv_cnt == 0)
					fail_out($sformatf("Timeout on test %s, no status_valid after the frame",
						tbl[n].name));
				check_val(tbl[n].name, "status_vec", tbl[n].expv, got_vec);
				check_val(tbl[n].name, "pack_len", frm.size(), got_len);
				check_val(tbl[n].name, "octets", frm.size(), got.size());
				foreach (frm[i])
					check_val(tbl[n].name, $sformatf("odata[%0d]", i), frm[i], got[i]);
			end
		end

		drive_idle(4);
		$display("Simulation passed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
scan_pkg.sv
scan_if.sv
rx_framer.sv
addr_match.sv
arp_match.sv
crc32_check.sv
scanner.sv
scanner_asserts.sv
tb_scanner.sv
